// File: src/scope_pkg.sv
// Shared widths, sample and bus structures, register map and capture states for the scope test
`default_nettype none

package scope_pkg;

    localparam int DATA_WIDTH    = 16;
    localparam int CHANNEL_WIDTH = 4;
    localparam int PERIOD_WIDTH  = 32;
    localparam int BUS_ADDR_WIDTH = 4;
    localparam int BUS_DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [CHANNEL_WIDTH-1:0]  channel_t;
    typedef logic [PERIOD_WIDTH-1:0]   period_t;
    typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;

    // One generated sample as it leaves the pattern generator
    typedef struct packed {
        logic     valid;
        channel_t channel;
        data_t    data;
    } sample_t;

    // Word kept in the capture buffer
    typedef struct packed {
        channel_t channel;
        data_t    data;
    } stored_sample_t;

    // Single-cycle register write from the bus
    typedef struct packed {
        logic      en;
        bus_addr_t addr;
        bus_data_t data;
    } reg_write_t;

    // Register map
    localparam bus_addr_t ADDR_CTRL       = 4'd0;
    localparam bus_addr_t ADDR_PERIOD     = 4'd1;
    localparam bus_addr_t ADDR_STATUS     = 4'd2;
    localparam bus_addr_t ADDR_READ_INDEX = 4'd3;
    localparam bus_addr_t ADDR_READ_DATA  = 4'd4;

    // CTRL bit positions
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_ARM_BIT    = 1;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_FILL,
        CAP_DONE
    } capture_state_t;

endpackage

`default_nettype wire

// File: src/scope_regs.sv
// Register file for the scope test, decoding bus writes and multiplexing bus reads
`default_nettype none

module scope_regs import scope_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  wire logic            clock,
    input  wire logic            rst,
    input  wire reg_write_t      bus_write,
    input  wire bus_addr_t       bus_read_addr,
    input  wire stored_sample_t  read_word,
    input  wire logic            busy,
    input  wire logic            done,
    output bus_data_t            bus_read_data,
    output logic                 timebase_enable,
    output period_t              period,
    output logic                 arm,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] read_index
);

    localparam int INDEX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic ctrl_write;

    assign ctrl_write = bus_write.en && (bus_write.addr == ADDR_CTRL);

    always_ff @(posedge clock) begin
        if (rst) begin
            timebase_enable <= 1'b0;
            period          <= '0;
            read_index      <= '0;
            arm             <= 1'b0;
        end else begin
            // The arm bit is self-clearing, so it only lives for one cycle
            arm <= ctrl_write && bus_write.data[CTRL_ARM_BIT];
            if (ctrl_write) begin
                timebase_enable <= bus_write.data[CTRL_ENABLE_BIT];
            end
            if (bus_write.en && (bus_write.addr == ADDR_PERIOD)) begin
                period <= period_t'(bus_write.data);
            end
            if (bus_write.en && (bus_write.addr == ADDR_READ_INDEX)) begin
                read_index <= bus_write.data[INDEX_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        bus_read_data = '0;
        case (bus_read_addr)
            ADDR_CTRL: begin
                bus_read_data[CTRL_ENABLE_BIT] = timebase_enable;
            end
            ADDR_PERIOD: begin
                bus_read_data = bus_data_t'(period);
            end
            ADDR_STATUS: begin
                bus_read_data[0] = done;
                bus_read_data[1] = busy;
            end
            ADDR_READ_INDEX: begin
                bus_read_data = bus_data_t'(read_index);
            end
            ADDR_READ_DATA: begin
                bus_read_data = bus_data_t'(read_word);
            end
            default: begin
                bus_read_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/sample_timebase.sv
// Programmable divider that emits one-cycle sample ticks every period+1 clock cycles
`default_nettype none

module sample_timebase import scope_pkg::*; (
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire logic    enable,
    input  wire period_t period,
    output logic         tick
);

    period_t count;

    always_ff @(posedge clock) begin
        if (rst || !enable) begin
            // Dropping the enable restarts the divider from zero
            count <= '0;
            tick  <= 1'b0;
        end else if (count >= period) begin
            // Greater-or-equal also catches a period that was lowered mid-count
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + period_t'(1);
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/test_pattern_gen.sv
// Test pattern source producing channel-rotating samples tagged with a frame index
`default_nettype none

module test_pattern_gen import scope_pkg::*; #(
    parameter int NUM_CHANNELS = 6
) (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic tick,
    input  wire logic restart,
    output sample_t   sample
);

    localparam data_t CHANNEL_STEP = data_t'(100);
    localparam channel_t LAST_CHANNEL = channel_t'(NUM_CHANNELS - 1);

    channel_t channel_count;
    data_t    frame_index;

    // Counters and valid are control state
    always_ff @(posedge clock) begin
        if (rst || restart) begin
            channel_count <= '0;
            frame_index   <= '0;
            sample.valid  <= 1'b0;
        end else begin
            sample.valid <= tick;
            if (tick) begin
                if (channel_count == LAST_CHANNEL) begin
                    channel_count <= '0;
                    frame_index   <= frame_index + data_t'(1);
                end else begin
                    channel_count <= channel_count + channel_t'(1);
                end
            end
        end
    end

    // Payload follows the counters on every tick
    always_ff @(posedge clock) begin
        if (tick) begin
            sample.channel <= channel_count;
            sample.data    <= frame_index + data_t'(channel_count) * CHANNEL_STEP;
        end
    end

endmodule

`default_nettype wire

// File: src/capture_control.sv
// Capture FSM that arms, fills the sample buffer to DEPTH entries and signals completion
`default_nettype none

module capture_control import scope_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire logic     arm,
    input  wire sample_t  sample,
    output logic          buf_write_en,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] buf_write_addr,
    output logic          busy,
    output logic          done,
    output logic          capture_done
);

    localparam int INDEX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [INDEX_WIDTH-1:0] LAST_ADDR = INDEX_WIDTH'(DEPTH - 1);

    capture_state_t state;
    capture_state_t state_next;
    logic           last_write;

    // Samples are only taken while filling, everything else is dropped
    assign buf_write_en = (state == CAP_FILL) && sample.valid;
    assign last_write   = buf_write_en && (buf_write_addr == LAST_ADDR);

    assign busy = (state == CAP_FILL);
    assign done = (state == CAP_DONE);

    always_comb begin
        state_next = state;
        if (arm) begin
            // A new arm restarts the capture from any state
            state_next = CAP_FILL;
        end else begin
            case (state)
                CAP_IDLE: state_next = CAP_IDLE;
                CAP_FILL: begin
                    if (last_write) begin
                        state_next = CAP_DONE;
                    end
                end
                CAP_DONE: state_next = CAP_DONE;
                default:  state_next = CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state          <= CAP_IDLE;
            buf_write_addr <= '0;
            capture_done   <= 1'b0;
        end else begin
            state <= state_next;
            // Pulse exactly once, on the edge that enters CAP_DONE
            capture_done <= !arm && last_write;
            if (arm) begin
                buf_write_addr <= '0;
            end else if (buf_write_en) begin
                buf_write_addr <= buf_write_addr + INDEX_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/capture_buffer.sv
// Sample memory with one write port from the controller and a registered read port
`default_nettype none

module capture_buffer import scope_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  wire logic    clock,
    input  wire logic    buf_write_en,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] buf_write_addr,
    input  wire sample_t sample,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] read_index,
    output stored_sample_t read_word
);

    stored_sample_t mem [DEPTH];

    stored_sample_t write_word;

    // The valid flag is not stored, only the channel tag and the value
    assign write_word.channel = sample.channel;
    assign write_word.data    = sample.data;

    always_ff @(posedge clock) begin
        if (buf_write_en && sample.valid) begin
            mem[buf_write_addr] <= write_word;
        end
    end

    // Read data appears one edge after the index changes
    always_ff @(posedge clock) begin
        read_word <= mem[read_index];
    end

endmodule

`default_nettype wire

// File: src/scope_test_top.sv
// Scope self-test top level joining the registers, timebase, pattern source, controller and buffer
`default_nettype none

module scope_test_top import scope_pkg::*; #(
    parameter int DEPTH        = 64,
    parameter int NUM_CHANNELS = 6
) (
    input  wire logic       clock,
    input  wire logic       rst,
    input  wire reg_write_t bus_write,
    input  wire bus_addr_t  bus_read_addr,
    output bus_data_t       bus_read_data,
    output logic            capture_done
);

    localparam int INDEX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic                   timebase_enable;
    period_t                period;
    logic                   arm;
    logic [INDEX_WIDTH-1:0] read_index;
    logic                   tick;
    sample_t                sample;
    logic                   buf_write_en;
    logic [INDEX_WIDTH-1:0] buf_write_addr;
    logic                   busy;
    logic                   done;
    stored_sample_t         read_word;

    scope_regs #(
        .DEPTH(DEPTH)
    ) regs (
        .clock(clock),
        .rst(rst),
        .bus_write(bus_write),
        .bus_read_addr(bus_read_addr),
        .read_word(read_word),
        .busy(busy),
        .done(done),
        .bus_read_data(bus_read_data),
        .timebase_enable(timebase_enable),
        .period(period),
        .arm(arm),
        .read_index(read_index)
    );

    sample_timebase timebase (
        .clock(clock),
        .rst(rst),
        .enable(timebase_enable),
        .period(period),
        .tick(tick)
    );

    // Arming also restarts the pattern so every capture begins at channel 0, index 0
    test_pattern_gen #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) pattern (
        .clock(clock),
        .rst(rst),
        .tick(tick),
        .restart(arm),
        .sample(sample)
    );

    capture_control #(
        .DEPTH(DEPTH)
    ) control (
        .clock(clock),
        .rst(rst),
        .arm(arm),
        .sample(sample),
        .buf_write_en(buf_write_en),
        .buf_write_addr(buf_write_addr),
        .busy(busy),
        .done(done),
        .capture_done(capture_done)
    );

    capture_buffer #(
        .DEPTH(DEPTH)
    ) buffer (
        .clock(clock),
        .buf_write_en(buf_write_en),
        .buf_write_addr(buf_write_addr),
        .sample(sample),
        .read_index(read_index),
        .read_word(read_word)
    );

endmodule

`default_nettype wire

// File: verif/scope_test_chk.sv
// Bound assertions on sample tick spacing and the capture controller status signals
`default_nettype none

module scope_test_chk import scope_pkg::*; (
    input wire logic    clock,
    input wire logic    rst,
    input wire logic    enable,
    input wire period_t period,
    input wire logic    tick,
    input wire logic    busy,
    input wire logic    done,
    input wire logic    capture_done
);

    period_t gap;
    logic    seen_tick;

    // Cycles since the last tick, restarted whenever the timebase is stopped
    always_ff @(posedge clock) begin
        if (rst || !enable) begin
            gap       <= '0;
            seen_tick <= 1'b0;
        end else if (tick) begin
            gap       <= '0;
            seen_tick <= 1'b1;
        end else begin
            gap <= gap + period_t'(1);
        end
    end

    tick_spacing: assert property (@(posedge clock) disable iff (rst)
        (enable && tick && seen_tick) |-> (gap == period))
        else $error("Sample ticks are not period+1 cycles apart");

    done_single_cycle: assert property (@(posedge clock) disable iff (rst)
        capture_done |=> !capture_done)
        else $error("capture_done stayed high for more than one cycle");

    busy_done_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(busy && done))
        else $error("busy and done are high together");

endmodule

// The top level is where the timebase and the controller nets meet
bind scope_test_top scope_test_chk chk (
    .clock(clock),
    .rst(rst),
    .enable(timebase_enable),
    .period(period),
    .tick(tick),
    .busy(busy),
    .done(done),
    .capture_done(capture_done)
);

`default_nettype wire

// File: verif/scope_test_tb.sv
// Testbench for the scope self-test, checking register access and captured buffer contents
`default_nettype none

module scope_test_tb import scope_pkg::*; ();

    localparam int DEPTH          = 64;
    localparam int NUM_CHANNELS   = 6;
    localparam int CLOCK_PERIOD   = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int SAMPLE_DELAY   = 30;
    localparam int RESET_CYCLES   = 10;
    localparam int CAPTURES       = 4;
    localparam int MAX_PERIOD     = 7;
    // Each capture takes at most DEPTH ticks of MAX_PERIOD+1 cycles, the rest covers readback
    localparam int TIMEOUT_CYCLES = CAPTURES * DEPTH * (MAX_PERIOD + 1) + 2000;

    logic       clock;
    logic       rst;
    reg_write_t bus_write;
    bus_addr_t  bus_read_addr;
    bus_data_t  bus_read_data;
    logic       capture_done;

    logic [31:0] rng_state;
    period_t     capture_period;
    int          done_pulses = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count;

    string     check_names[$];
    bus_data_t check_actuals[$];
    bus_data_t check_expecteds[$];

    scope_test_top #(
        .DEPTH(DEPTH),
        .NUM_CHANNELS(NUM_CHANNELS)
    ) UUT (
        .clock(clock),
        .rst(rst),
        .bus_write(bus_write),
        .bus_read_addr(bus_read_addr),
        .bus_read_data(bus_read_data),
        .capture_done(capture_done)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Entry k holds channel k mod N and the value (k div N) + 100 * channel, zero-extended
    function automatic bus_data_t expected_word(input int k);
        int        channel;
        int        value;
        bus_data_t word;
        channel     = k % NUM_CHANNELS;
        value       = k / NUM_CHANNELS + 100 * channel;
        word        = '0;
        word[19:16] = channel[3:0];
        word[15:0]  = value[15:0];
        return word;
    endfunction

    task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
        @(posedge clock);
        #DRIVE_DELAY;
        bus_write.en   = 1'b1;
        bus_write.addr = addr;
        bus_write.data = data;
        @(posedge clock);
        #DRIVE_DELAY;
        bus_write.en = 1'b0;
    endtask

    task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
        @(posedge clock);
        #DRIVE_DELAY;
        bus_read_addr = addr;
        #SAMPLE_DELAY;
        data = bus_read_data;
    endtask

    task automatic queue_check(input string name, input bus_data_t actual,
                               input bus_data_t expected);
        check_names.push_back(name);
        check_actuals.push_back(actual);
        check_expecteds.push_back(expected);
    endtask

    task automatic compare_reg(input string name, input bus_addr_t addr,
                               input bus_data_t expected);
        bus_data_t value;
        read_reg(addr, value);
        queue_check(name, value, expected);
    endtask

    task automatic read_back_buffer();
        for (int k = 0; k < DEPTH; k++) begin
            write_reg(ADDR_READ_INDEX, bus_data_t'(k));
            compare_reg($sformatf("READ_DATA[%0d]", k), ADDR_READ_DATA, expected_word(k));
        end
    endtask

    // The timebase is stopped before the period changes, then started together with the arm
    task automatic arm_capture(input period_t new_period);
        write_reg(ADDR_CTRL, 32'h0);
        write_reg(ADDR_PERIOD, bus_data_t'(new_period));
        write_reg(ADDR_CTRL, 32'h3);
    endtask

    task automatic wait_for_pulses(input int target);
        while (done_pulses < target) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
    endtask

    task automatic finish_capture(input int total_pulses);
        wait_for_pulses(total_pulses);
        // A few more cycles would expose a repeated completion pulse
        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        queue_check("capture_done pulses", bus_data_t'(done_pulses), bus_data_t'(total_pulses));
        compare_reg("STATUS", ADDR_STATUS, 32'h1);
        read_back_buffer();
    endtask

    always @(posedge clock) begin
        if (!rst && capture_done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    // Queued checks are compared on the falling edge, away from the drive and sample points
    always @(negedge clock) begin
        string     name;
        bus_data_t actual;
        bus_data_t expected;
        while (check_names.size() != 0) begin
            name     = check_names.pop_front();
            actual   = check_actuals.pop_front();
            expected = check_expecteds.pop_front();
            check_count++;
            assert (actual == expected) else begin
                error_count++;
                $display("FAIL at %0t: %s = %h, expected %h", $time, name, actual, expected);
            end
        end
    end

    initial begin
        rst           = 1'b1;
        bus_write     = '0;
        bus_read_addr = '0;
        rng_state     = 32'h7f2d_da42;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Register access after reset
        compare_reg("STATUS", ADDR_STATUS, 32'h0);
        repeat (4) begin
            rng_state = xorshift32(rng_state);
            write_reg(ADDR_PERIOD, rng_state);
            compare_reg("PERIOD", ADDR_PERIOD, rng_state);
        end

        // Capture with a tick on every cycle
        arm_capture('0);
        finish_capture(1);

        // Capture with a slower random period
        rng_state      = xorshift32(rng_state);
        capture_period = period_t'(rng_state % MAX_PERIOD + 1);
        arm_capture(capture_period);
        finish_capture(2);

        // Re-arm from CAP_DONE without touching the timebase
        write_reg(ADDR_CTRL, 32'h3);
        compare_reg("STATUS", ADDR_STATUS, 32'h2);
        finish_capture(3);

        // Stop the timebase part way through a capture, then let it finish
        rng_state      = xorshift32(rng_state);
        capture_period = period_t'(rng_state % MAX_PERIOD + 1);
        arm_capture(capture_period);
        repeat (10 * (capture_period + 1)) @(posedge clock);
        write_reg(ADDR_CTRL, 32'h0);
        repeat (100) @(posedge clock);
        #DRIVE_DELAY;
        queue_check("capture_done pulses", bus_data_t'(done_pulses), bus_data_t'(3));
        compare_reg("STATUS", ADDR_STATUS, 32'h2);
        write_reg(ADDR_CTRL, 32'h1);
        finish_capture(4);

        @(negedge clock);
        @(negedge clock);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/scope_pkg.sv
src/scope_regs.sv
src/sample_timebase.sv
src/test_pattern_gen.sv
src/capture_control.sv
src/capture_buffer.sv
src/scope_test_top.sv
verif/scope_test_chk.sv
verif/scope_test_tb.sv

// File: Bender.yml
package:
  name: scope_test

sources:
  - files:
      - src/scope_pkg.sv
      - src/scope_regs.sv
      - src/sample_timebase.sv
      - src/test_pattern_gen.sv
      - src/capture_control.sv
      - src/capture_buffer.sv
      - src/scope_test_top.sv
  - target: test
    files:
      - verif/scope_test_chk.sv
      - verif/scope_test_tb.sv
